// File: rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer entries, power of two
`define ROB_DEPTH 16

// store queue slots, power of two
`define SQ_DEPTH 8

// architectural registers
`define REG_NUM 32

// data and address width
`define XLEN 32

`endif

// File: rob_pkg.sv
`include "rob_defines.svh"

package rob_pkg;

    localparam int NICK_W  = $clog2(`ROB_DEPTH);
    localparam int REGNM_W = $clog2(`REG_NUM);

    typedef logic [NICK_W-1:0]  nick_t;
    typedef logic [REGNM_W-1:0] regnm_t;
    typedef logic [`XLEN-1:0]   data_t;

    typedef enum logic [1:0] {
        kind_alu,
        kind_branch,
        kind_store
    } rob_kind_t;

    typedef struct packed {
        rob_kind_t kind;
        regnm_t    regnm;
        logic      done;
        logic      pred_taken;
        logic      act_taken;
        data_t     data;
        // branch target, unused for other kinds
        data_t     target;
    } rob_entry_t;

endpackage

// File: rob_if.sv
`timescale 1ns/1ns

interface dispatch_if;
    import rob_pkg::*;

    logic      en;
    rob_kind_t kind;
    regnm_t    regnm;
    logic      pred_taken;
    // tail nick, returned combinationally
    nick_t     nick;

    modport src (output en, output kind, output regnm, output pred_taken, input nick);
    modport rob (input en, input kind, input regnm, input pred_taken, output nick);
    modport mon (input en, input kind, input regnm, input pred_taken, input nick);
endinterface

interface complete_if;
    import rob_pkg::*;

    logic  en;
    nick_t nick;
    // result value, or store data
    data_t data;
    logic  taken;
    // branch target, or store address
    data_t target;

    modport src (output en, output nick, output data, output taken, output target);
    modport rob (input en, input nick, input data, input taken, input target);
endinterface

// File: reorder_buffer.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module reorder_buffer (
    input  logic            clk,
    input  logic            rst,
    dispatch_if.rob         dp,
    complete_if.rob         cp,
    input  logic            st_done,
    input  rob_pkg::nick_t  st_done_nick,
    input  logic            store_retired,
    output logic            full,
    output logic            commit_en,
    output rob_pkg::regnm_t commit_regnm,
    output rob_pkg::nick_t  commit_nick,
    output rob_pkg::data_t  commit_data,
    output logic            st_release,
    output logic            flush,
    output rob_pkg::data_t  redirect_pc
);
    import rob_pkg::*;

    localparam int unsigned DEPTH = `ROB_DEPTH;

    rob_entry_t       entries [DEPTH];
    logic [DEPTH-1:0] valid;
    nick_t            head;
    nick_t            tail;
    logic [NICK_W:0]  count;
    // head store handed to the store queue, waiting for ack
    logic             released;

    rob_entry_t       head_e;
    logic             head_ready;
    logic             mispredict;
    logic             do_commit;
    logic             do_release;
    logic             do_st_retire;
    logic             retire;

    assign head_e     = entries[head];
    assign head_ready = valid[head] && head_e.done;

    assign mispredict = head_ready && head_e.kind == kind_branch &&
                        head_e.pred_taken != head_e.act_taken;
    assign do_commit  = head_ready && head_e.kind != kind_store && !mispredict;
    assign do_release = head_ready && head_e.kind == kind_store && !released;

    assign do_st_retire = released && store_retired;
    assign retire       = do_commit || do_st_retire;

    assign dp.nick = tail;
    // also closed during the flush cycle so nothing slips past the clear
    assign full    = (count == DEPTH[NICK_W:0]) || flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            released   <= 1'b0;
            commit_en  <= 1'b0;
            st_release <= 1'b0;
            flush      <= 1'b0;
        end else if (mispredict) begin
            // wrong path, drop everything behind the branch
            valid      <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            released   <= 1'b0;
            commit_en  <= 1'b0;
            st_release <= 1'b0;
            flush      <= 1'b1;
        end else begin
            flush      <= 1'b0;
            commit_en  <= do_commit;
            st_release <= do_release;

            if (dp.en) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end

            if (retire) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end

            if (do_release) begin
                released <= 1'b1;
            end else if (do_st_retire) begin
                released <= 1'b0;
            end

            count <= count + (NICK_W+1)'(dp.en) - (NICK_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (dp.en) begin
            entries[tail] <= '{kind:       dp.kind,
                               regnm:      dp.regnm,
                               done:       1'b0,
                               pred_taken: dp.pred_taken,
                               act_taken:  1'b0,
                               data:       '0,
                               target:     '0};
        end

        // late results for flushed nicks are ignored
        if (cp.en && valid[cp.nick]) begin
            entries[cp.nick].data      <= cp.data;
            entries[cp.nick].act_taken <= cp.taken;
            entries[cp.nick].target    <= cp.target;
            entries[cp.nick].done      <= 1'b1;
        end

        if (st_done && valid[st_done_nick]) begin
            entries[st_done_nick].done <= 1'b1;
        end

        if (do_commit) begin
            commit_regnm <= head_e.regnm;
            commit_nick  <= head;
            commit_data  <= head_e.data;
        end

        if (mispredict) begin
            redirect_pc <= head_e.target;
        end
    end

endmodule

// File: rename_table.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module rename_table (
    input  logic            clk,
    input  logic            rst,
    dispatch_if.mon         dp,
    input  logic            commit_en,
    input  rob_pkg::regnm_t commit_regnm,
    input  rob_pkg::nick_t  commit_nick,
    input  logic            flush,
    input  rob_pkg::regnm_t rd_regnm,
    output logic            rd_busy,
    output rob_pkg::nick_t  rd_nick
);
    import rob_pkg::*;

    nick_t               map [`REG_NUM];
    logic [`REG_NUM-1:0] busy;
    logic                alloc;

    // x0 and stores never own a mapping
    assign alloc = dp.en && dp.kind != kind_store && dp.regnm != '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            // an older commit must not clear a younger mapping
            if (commit_en && map[commit_regnm] == commit_nick) begin
                busy[commit_regnm] <= 1'b0;
            end
            if (alloc) begin
                busy[dp.regnm] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            map[dp.regnm] <= dp.nick;
        end
    end

    assign rd_busy = busy[rd_regnm];
    // nick only meaningful while busy
    assign rd_nick = busy[rd_regnm] ? map[rd_regnm] : '0;

endmodule

// File: reg_file.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module reg_file (
    input  logic            clk,
    input  logic            rst,
    input  logic            commit_en,
    input  rob_pkg::regnm_t commit_regnm,
    input  rob_pkg::data_t  commit_data,
    input  rob_pkg::regnm_t rd_regnm,
    output rob_pkg::data_t  rd_data
);
    import rob_pkg::*;

    data_t regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_en && commit_regnm != '0) begin
            regs[commit_regnm] <= commit_data;
        end
    end

    // x0 is hardwired
    assign rd_data = (rd_regnm == '0) ? '0 : regs[rd_regnm];

endmodule

// File: store_queue.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module store_queue (
    input  logic               clk,
    input  logic               rst,
    dispatch_if.mon            dp,
    complete_if.rob            sp,
    output logic               st_done,
    output rob_pkg::nick_t     st_done_nick,
    input  logic               st_release,
    output logic               store_retired,
    input  logic               flush,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output rob_pkg::data_t     wb_adr,
    output rob_pkg::data_t     wb_dat_o,
    output logic [`XLEN/8-1:0] wb_sel,
    input  logic               wb_ack
);
    import rob_pkg::*;

    localparam int SQ_W = $clog2(`SQ_DEPTH);

    nick_t                slot_nick [`SQ_DEPTH];
    data_t                slot_adr  [`SQ_DEPTH];
    data_t                slot_dat  [`SQ_DEPTH];
    logic [`SQ_DEPTH-1:0] vld;
    logic [SQ_W-1:0]      head;
    logic [SQ_W-1:0]      tail;
    logic                 alloc;
    logic                 hit;
    logic [SQ_W-1:0]      hit_idx;
    logic                 keep_head;

    assign alloc = dp.en && dp.kind == kind_store;

    // find the slot waiting on this store completion
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if (vld[i] && slot_nick[i] == sp.nick) begin
                hit     = 1'b1;
                hit_idx = i[SQ_W-1:0];
            end
        end
    end

    assign st_done      = sp.en && hit;
    assign st_done_nick = sp.nick;

    assign store_retired = wb_cyc && wb_ack;
    // released head survives a flush
    assign keep_head     = wb_cyc && !wb_ack;

    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc;
    assign wb_sel = '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld    <= '0;
            head   <= '0;
            tail   <= '0;
            wb_cyc <= 1'b0;
        end else begin
            if (alloc) begin
                vld[tail] <= 1'b1;
                tail      <= tail + 1'b1;
            end

            if (store_retired) begin
                wb_cyc    <= 1'b0;
                vld[head] <= 1'b0;
                head      <= head + 1'b1;
            end else if (st_release) begin
                wb_cyc <= 1'b1;
            end

            if (flush) begin
                for (int i = 0; i < `SQ_DEPTH; i++) begin
                    if (!(keep_head && i[SQ_W-1:0] == head)) begin
                        vld[i] <= 1'b0;
                    end
                end
                tail <= wb_cyc ? head + 1'b1 : head;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_nick[tail] <= dp.nick;
        end
        if (sp.en && hit) begin
            slot_adr[hit_idx] <= sp.target;
            slot_dat[hit_idx] <= sp.data;
        end
        if (st_release && !wb_cyc) begin
            wb_adr   <= slot_adr[head];
            wb_dat_o <= slot_dat[head];
        end
    end

endmodule

// File: rob_core.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module rob_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_en,
    input  rob_pkg::rob_kind_t issue_kind,
    input  rob_pkg::regnm_t    issue_regnm,
    input  logic               issue_pred_taken,
    output rob_pkg::nick_t     issue_nick,
    output logic               full,
    input  logic               ex_en,
    input  rob_pkg::nick_t     ex_nick,
    input  rob_pkg::data_t     ex_data,
    input  logic               ex_taken,
    input  rob_pkg::data_t     ex_target,
    input  logic               st_en,
    input  rob_pkg::nick_t     st_nick,
    input  rob_pkg::data_t     st_addr,
    input  rob_pkg::data_t     st_data,
    output logic               commit_en,
    output rob_pkg::regnm_t    commit_regnm,
    output rob_pkg::data_t     commit_data,
    output logic               flush,
    output rob_pkg::data_t     redirect_pc,
    input  rob_pkg::regnm_t    rd_regnm,
    output rob_pkg::data_t     rd_data,
    output logic               rd_busy,
    output rob_pkg::nick_t     rd_nick,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output rob_pkg::data_t     wb_adr,
    output rob_pkg::data_t     wb_dat_o,
    output logic [`XLEN/8-1:0] wb_sel,
    input  logic               wb_ack
);
    import rob_pkg::*;

    dispatch_if dp_bus ();
    complete_if ex_bus ();
    complete_if st_bus ();

    logic  st_done;
    nick_t st_done_nick;
    logic  st_release;
    logic  store_retired;
    nick_t commit_nick;

    // issue is blocked here for every block at once
    assign dp_bus.en         = issue_en && !full;
    assign dp_bus.kind       = issue_kind;
    assign dp_bus.regnm      = issue_regnm;
    assign dp_bus.pred_taken = issue_pred_taken;
    assign issue_nick        = dp_bus.nick;

    assign ex_bus.en     = ex_en;
    assign ex_bus.nick   = ex_nick;
    assign ex_bus.data   = ex_data;
    assign ex_bus.taken  = ex_taken;
    assign ex_bus.target = ex_target;

    // store port, address rides on target
    assign st_bus.en     = st_en;
    assign st_bus.nick   = st_nick;
    assign st_bus.data   = st_data;
    assign st_bus.taken  = 1'b0;
    assign st_bus.target = st_addr;

    reorder_buffer rob_i (
        .clk           (clk),
        .rst           (rst),
        .dp            (dp_bus.rob),
        .cp            (ex_bus.rob),
        .st_done       (st_done),
        .st_done_nick  (st_done_nick),
        .store_retired (store_retired),
        .full          (full),
        .commit_en     (commit_en),
        .commit_regnm  (commit_regnm),
        .commit_nick   (commit_nick),
        .commit_data   (commit_data),
        .st_release    (st_release),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

    rename_table rename_i (
        .clk          (clk),
        .rst          (rst),
        .dp           (dp_bus.mon),
        .commit_en    (commit_en),
        .commit_regnm (commit_regnm),
        .commit_nick  (commit_nick),
        .flush        (flush),
        .rd_regnm     (rd_regnm),
        .rd_busy      (rd_busy),
        .rd_nick      (rd_nick)
    );

    reg_file rf_i (
        .clk          (clk),
        .rst          (rst),
        .commit_en    (commit_en),
        .commit_regnm (commit_regnm),
        .commit_data  (commit_data),
        .rd_regnm     (rd_regnm),
        .rd_data      (rd_data)
    );

    store_queue sq_i (
        .clk           (clk),
        .rst           (rst),
        .dp            (dp_bus.mon),
        .sp            (st_bus.rob),
        .st_done       (st_done),
        .st_done_nick  (st_done_nick),
        .st_release    (st_release),
        .store_retired (store_retired),
        .flush         (flush),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_o      (wb_dat_o),
        .wb_sel        (wb_sel),
        .wb_ack        (wb_ack)
    );

endmodule

// File: rob_checker.sv
`timescale 1ns/1ns

module rob_checker (
    input logic           clk,
    input logic           rst,
    input logic           commit_en,
    input logic           flush,
    input logic           issue_en,
    input logic           tail_valid,
    input logic           wb_stb,
    input logic           wb_ack,
    input rob_pkg::data_t wb_adr,
    input rob_pkg::data_t wb_dat_o
);

    // nothing commits in the flush cycle or in the cycle after it
    assert property (@(posedge clk) disable iff (rst) !(commit_en && (flush || $past(flush))))
        else $error("commit_en alongside or right after flush");

    // classic cycle holds stb, address and data until ack
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o))
        else $error("wb_stb, wb_adr or wb_dat_o changed before wb_ack");

    // an accepted issue lands on a free entry
    assert property (@(posedge clk) disable iff (rst) !(issue_en && tail_valid))
        else $error("issue accepted onto a live entry");

endmodule

bind reorder_buffer rob_checker rob_chk_i (
    .clk        (clk),
    .rst        (rst),
    .commit_en  (commit_en),
    .flush      (flush),
    .issue_en   (dp.en),
    .tail_valid (valid[tail]),
    .wb_stb     (1'b0),
    .wb_ack     (1'b0),
    .wb_adr     ('0),
    .wb_dat_o   ('0)
);

bind store_queue rob_checker sq_chk_i (
    .clk        (clk),
    .rst        (rst),
    .commit_en  (1'b0),
    .flush      (1'b0),
    .issue_en   (1'b0),
    .tail_valid (1'b0),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o)
);

// File: rob_tb.sv
`timescale 1ns/1ns
`include "rob_defines.svh"

module rob_tb;
    import rob_pkg::*;

    typedef struct packed {
        rob_kind_t kind;
        regnm_t    regnm;
        data_t     value;
        logic      pred;
        logic      act;
        data_t     target;
        data_t     addr;
        // closes a group of rows issued together
        logic      last;
    } row_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic issue_en = 1'b0;
    rob_kind_t issue_kind = kind_alu;
    regnm_t issue_regnm = '0;
    logic issue_pred_taken = 1'b0;
    nick_t issue_nick;
    logic full;
    logic ex_en = 1'b0;
    nick_t ex_nick = '0;
    data_t ex_data = '0;
    logic ex_taken = 1'b0;
    data_t ex_target = '0;
    logic st_en = 1'b0;
    nick_t st_nick = '0;
    data_t st_addr = '0;
    data_t st_data = '0;
    logic commit_en;
    regnm_t commit_regnm;
    data_t commit_data;
    logic flush;
    data_t redirect_pc;
    regnm_t rd_regnm = '0;
    data_t rd_data;
    logic rd_busy;
    nick_t rd_nick;
    logic wb_cyc, wb_stb, wb_we;
    data_t wb_adr, wb_dat_o;
    logic [`XLEN/8-1:0] wb_sel;
    logic wb_ack = 1'b0;

    row_t rows[$];
    nick_t nicks[64];
    int order[64];
    regnm_t exp_regnm[$];
    data_t exp_cdata[$];
    data_t exp_adr[$];
    data_t exp_wdat[$];
    data_t model_regs[`REG_NUM];
    logic flush_pending = 1'b0;
    data_t flush_target = '0;
    nick_t model_tail = '0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 1000000;
    logic [31:0] shuffle_seed = 32'd24;
    logic [31:0] mem_seed = 32'd24;
    int mem_wait = 0;
    logic mem_busy = 1'b0;

    rob_core rob_core_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_regnm(input string name, input regnm_t got, input regnm_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_nick(input string name, input nick_t got, input nick_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("%s at cycle %0d", what, cycles);
    endtask

    task automatic add_row(input rob_kind_t k, input regnm_t r, input data_t v, input logic p,
                           input logic a, input data_t t, input data_t ad, input logic l);
        rows.push_back(row_t'{k, r, v, p, a, t, ad, l});
    endtask

    task automatic build_table;
        // five results completed out of order
        for (int k = 0; k < 5; k++) begin
            add_row(kind_alu, regnm_t'(k + 1), 32'h100 + k, 0, 0, 0, 0, k == 4);
        end
        // fills the buffer, rewrites r1..r8 twice, wraps the tail
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            add_row(kind_alu, regnm_t'(k % 8 + 1), 32'h5000 + k, 0, 0, 0, 0,
                    k == `ROB_DEPTH - 1);
        end
        add_row(kind_store, 0, 32'hcafe0001, 0, 0, 0, 32'h1000, 0);
        add_row(kind_alu, 9, 32'h99, 0, 0, 0, 0, 0);
        add_row(kind_store, 0, 32'hcafe0002, 0, 0, 0, 32'h1004, 0);
        add_row(kind_branch, 20, 32'h20, 1, 1, 32'h200, 0, 0);
        add_row(kind_store, 0, 32'hcafe0003, 0, 0, 0, 32'h1008, 0);
        add_row(kind_store, 0, 32'hcafe0004, 0, 0, 0, 32'h100c, 1);
        // mispredict, the last three are wrong path
        add_row(kind_alu, 10, 32'ha0, 0, 0, 0, 0, 0);
        add_row(kind_store, 0, 32'hbeef0001, 0, 0, 0, 32'h2000, 0);
        add_row(kind_branch, 11, 32'h11, 0, 1, 32'h400, 0, 0);
        add_row(kind_alu, 12, 32'hc0, 0, 0, 0, 0, 0);
        add_row(kind_store, 0, 32'hdead0001, 0, 0, 0, 32'h2004, 0);
        add_row(kind_alu, 13, 32'hd0, 0, 0, 0, 0, 1);
        add_row(kind_alu, 14, 32'he0, 0, 0, 0, 0, 0);
        add_row(kind_alu, 15, 32'hf0, 0, 0, 0, 0, 0);
        add_row(kind_branch, 16, 32'h16, 0, 0, 32'h500, 0, 1);
    endtask

    task automatic issue_row(input row_t r, output nick_t n);
        while (full) begin
            @(posedge clk);
            #1;
        end
        issue_en = 1'b1;
        issue_kind = r.kind;
        issue_regnm = r.regnm;
        issue_pred_taken = r.pred;
        check_nick("issue_nick", issue_nick, model_tail);
        n = model_tail;
        @(posedge clk);
        #1;
        issue_en = 1'b0;
        model_tail = model_tail + 1'b1;
    endtask

    task automatic expect_row(input row_t r, inout logic wrong);
        if (!wrong) begin
            if (r.kind == kind_store) begin
                exp_adr.push_back(r.addr);
                exp_wdat.push_back(r.value);
            end else if (r.kind == kind_branch && r.pred != r.act) begin
                flush_pending = 1'b1;
                flush_target = r.target;
                wrong = 1'b1;
            end else begin
                exp_regnm.push_back(r.regnm);
                exp_cdata.push_back(r.value);
                if (r.regnm != '0) model_regs[r.regnm] = r.value;
            end
        end
    endtask

    task automatic complete_row(input row_t r, input nick_t n);
        if (r.kind == kind_store) begin
            st_en = 1'b1;
            st_nick = n;
            st_addr = r.addr;
            st_data = r.value;
        end else begin
            ex_en = 1'b1;
            ex_nick = n;
            ex_data = r.value;
            ex_taken = r.act;
            ex_target = r.target;
        end
        @(posedge clk);
        #1;
        ex_en = 1'b0;
        st_en = 1'b0;
    endtask

    task automatic drain;
        while (exp_regnm.size() != 0 || exp_adr.size() != 0 || flush_pending) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_regs;
        for (int k = 0; k < `REG_NUM; k++) begin
            @(posedge clk);
            #1;
            rd_regnm = regnm_t'(k);
            #1;
            check_data("rd_data", rd_data, model_regs[k]);
            check_bit("rd_busy", rd_busy, 1'b0);
        end
    endtask

    // commit and flush monitor
    always @(posedge clk) begin
        #1;
        if (!rst && commit_en) begin
            if (exp_regnm.size() == 0) begin
                report("commit with nothing expected");
            end else begin
                check_regnm("commit_regnm", commit_regnm, exp_regnm.pop_front());
                check_data("commit_data", commit_data, exp_cdata.pop_front());
            end
        end
        if (!rst && flush) begin
            if (!flush_pending) begin
                report("flush with no mispredicted branch");
            end else begin
                check_data("redirect_pc", redirect_pc, flush_target);
                flush_pending = 1'b0;
            end
        end
    end

    // wishbone memory with a random acknowledge delay
    always @(posedge clk) begin
        #1;
        if (rst) begin
            wb_ack = 1'b0;
            mem_busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
            mem_busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_seed = lcg_next(mem_seed);
                mem_wait = (mem_seed >> 16) % 5;
            end
            if (mem_wait == 0) begin
                wb_ack = 1'b1;
                check_bit("wb_we", wb_we, 1'b1);
                check_bit("wb_sel", &wb_sel, 1'b1);
                if (exp_adr.size() == 0) begin
                    report("store reached memory with nothing expected");
                end else begin
                    check_data("wb_adr", wb_adr, exp_adr.pop_front());
                    check_data("wb_dat_o", wb_dat_o, exp_wdat.pop_front());
                end
            end else begin
                mem_wait--;
                // the store at the head holds retirement
                check_bit("commit_en", commit_en, 1'b0);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int i;
        int start;
        int n;
        int j;
        int tmp;
        int err0;
        int test;
        logic wrong;
        row_t ra;
        row_t rb;
        nick_t na;
        nick_t nb;

        build_table();
        limit = 40 * (rows.size() + 2) + 200;
        for (int k = 0; k < `REG_NUM; k++) model_regs[k] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_bit("commit_en", commit_en, 1'b0);
        check_bit("flush", flush, 1'b0);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("full", full, 1'b0);
        read_regs();
        $display("test 0: reset state, %0d errors", errors);

        i = 0;
        test = 1;
        while (i < rows.size()) begin
            start = i;
            err0 = errors;
            wrong = 1'b0;
            do begin
                issue_row(rows[i], nicks[i]);
                expect_row(rows[i], wrong);
                i++;
            end while (!rows[i-1].last);
            n = i - start;
            check_bit("full", full, n == `ROB_DEPTH);

            for (int k = 0; k < n; k++) order[k] = start + k;
            for (int k = n - 1; k > 0; k--) begin
                shuffle_seed = lcg_next(shuffle_seed);
                j = (shuffle_seed >> 16) % (k + 1);
                tmp = order[k];
                order[k] = order[j];
                order[j] = tmp;
            end
            for (int k = 0; k < n; k++) complete_row(rows[order[k]], nicks[order[k]]);
            drain();
            check_bit("full", full, 1'b0);
            if (wrong) model_tail = '0;
            $display("test %0d: %0d rows, %0d errors", test, n, errors - err0);
            test++;
        end

        err0 = errors;
        read_regs();
        $display("test %0d: register readback, %0d errors", test, errors - err0);
        test++;

        // older write to r7 commits, younger mapping must stay busy
        err0 = errors;
        wrong = 1'b0;
        ra = '{kind_alu, 7, 32'h7a, 0, 0, 0, 0, 0};
        rb = '{kind_alu, 7, 32'h7b, 0, 0, 0, 0, 1};
        issue_row(ra, na);
        expect_row(ra, wrong);
        issue_row(rb, nb);
        expect_row(rb, wrong);
        complete_row(ra, na);
        while (exp_regnm.size() > 1) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        rd_regnm = 7;
        #1;
        check_bit("rd_busy", rd_busy, 1'b1);
        check_nick("rd_nick", rd_nick, nb);
        complete_row(rb, nb);
        drain();
        #1;
        check_bit("rd_busy", rd_busy, 1'b0);
        check_data("rd_data", rd_data, model_regs[7]);
        $display("test %0d: rename busy, %0d errors", test, errors - err0);
        test++;

        $display("%0d tests, %0d checks, %0d errors", test, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
rob_pkg.sv
rob_if.sv
reorder_buffer.sv
rename_table.sv
reg_file.sv
store_queue.sv
rob_core.sv
rob_checker.sv
rob_tb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f files.f \
    -o rob_sim > build.log 2>&1 \
    && ./obj_dir/rob_sim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
